//--- Bender.yml
package:
  name: lsu

sources:
  - rtl/lsuPkg.sv
  - rtl/memPkg.sv
  - rtl/reqBuffer.sv
  - rtl/dcache.sv
  - rtl/memCtrl.sv
  - rtl/loadFormat.sv
  - rtl/lsuTop.sv
  - target: simulation
    files:
      - testbench/lsuTb.sv

//--- lsu.f
rtl/lsuPkg.sv
rtl/memPkg.sv
rtl/reqBuffer.sv
rtl/dcache.sv
rtl/memCtrl.sv
rtl/loadFormat.sv
rtl/lsuTop.sv
testbench/lsuTb.sv

//--- rtl/dcache.sv
`timescale 1ns/1ps

module dcache (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rdy,
    input  logic                         issue,
    input  logic                         issueStore,
    input  logic [lsuPkg::lenWidth-1:0]  issueLen,
    input  logic [memPkg::addrWidth-1:0] issueAddr,
    input  logic [lsuPkg::wordWidth-1:0] issueData,
    input  logic [lsuPkg::tagWidth-1:0]  issueTag,
    input  logic                         memDone,
    input  memPkg::dataWord              memRdata,
    output logic                         busy,
    output logic                         memEn,
    output logic                         memStore,
    output logic [lsuPkg::lenWidth-1:0]  memLen,
    output logic [memPkg::addrWidth-1:0] memAddr,
    output memPkg::dataWord              memData,
    output logic                         done,
    output memPkg::dataWord              doneData,
    output logic [lsuPkg::tagWidth-1:0]  doneTag
);

    // tag of the one request in flight.
    logic [lsuPkg::tagWidth-1:0] tag;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // occupancy and strobes.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            memEn <= 1'b0;
            done  <= 1'b0;
        end else if (rdy) begin
            memEn <= issue;
            done  <= memDone;
            // issue only arrives while idle, so the two never overlap.
            if (issue) begin
                busy <= 1'b1;
            end else if (memDone) begin
                busy <= 1'b0;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request and completion fields.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rdy) begin
            if (issue) begin
                memStore     <= issueStore;
                memLen       <= issueLen;
                memAddr      <= issueAddr;
                memData.word <= issueData;
                tag          <= issueTag;
            end
            if (memDone) begin
                doneData <= memRdata;
                doneTag  <= tag;
            end
        end
    end

endmodule

//--- rtl/loadFormat.sv
`timescale 1ns/1ps

module loadFormat (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rdy,
    input  logic                         issue,
    input  logic [lsuPkg::opWidth-1:0]   issueOp,
    input  logic                         done,
    input  memPkg::dataWord              doneData,
    output logic                         respValid,
    output logic [lsuPkg::wordWidth-1:0] respData
);

    // a new op can be queued in the same cycle the previous one completes.
    logic [lsuPkg::opWidth-1:0]     opQ [lsuPkg::fmtDepth];
    logic [lsuPkg::fmtPtrWidth-1:0] wrPtr;
    logic [lsuPkg::fmtPtrWidth-1:0] rdPtr;
    logic [memPkg::byteWidth-1:0]   lowByte;
    logic [memPkg::halfWidth-1:0]   lowHalf;
    logic [lsuPkg::wordWidth-1:0]   extended;

    assign lowByte = doneData.word[memPkg::byteWidth-1:0];
    assign lowHalf = doneData.word[memPkg::halfWidth-1:0];

    always_comb begin
        case (opQ[rdPtr])
            lsuPkg::opLb:  extended = lsuPkg::wordWidth'(signed'(lowByte));
            lsuPkg::opLbu: extended = lsuPkg::wordWidth'(lowByte);
            lsuPkg::opLh:  extended = lsuPkg::wordWidth'(signed'(lowHalf));
            lsuPkg::opLhu: extended = lsuPkg::wordWidth'(lowHalf);
            lsuPkg::opLw:  extended = doneData.word;
            // stores.
            default:       extended = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            respValid <= 1'b0;
        end else if (rdy) begin
            respValid <= done;
            if (issue) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (done) begin
                rdPtr <= rdPtr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (issue) begin
                opQ[wrPtr] <= issueOp;
            end
            if (done) begin
                respData <= extended;
            end
        end
    end

endmodule

//--- rtl/lsuPkg.sv
package lsuPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // memory op codes.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int opWidth = 3;

    localparam logic [opWidth-1:0] opLb  = 3'd0;
    localparam logic [opWidth-1:0] opLh  = 3'd1;
    localparam logic [opWidth-1:0] opLw  = 3'd2;
    localparam logic [opWidth-1:0] opLbu = 3'd3;
    localparam logic [opWidth-1:0] opLhu = 3'd4;
    localparam logic [opWidth-1:0] opSb  = 3'd5;
    localparam logic [opWidth-1:0] opSh  = 3'd6;
    localparam logic [opWidth-1:0] opSw  = 3'd7;

    // access length, held as byte count minus one.
    localparam int lenWidth = 2;

    localparam logic [lenWidth-1:0] lenByte = 2'd0;
    localparam logic [lenWidth-1:0] lenHalf = 2'd1;
    localparam logic [lenWidth-1:0] lenWord = 2'd3;

    // request address and data words, and the reorder tag.
    localparam int wordWidth = 32;
    localparam int tagWidth  = 4;

    // request buffer and format queue sizing.
    localparam int bufDepth    = 4;
    localparam int ptrWidth    = $clog2(bufDepth);
    localparam int countWidth  = ptrWidth + 1;
    localparam int fmtDepth    = 2;
    localparam int fmtPtrWidth = $clog2(fmtDepth);

endpackage

//--- rtl/lsuTop.sv
`timescale 1ns/1ps

module lsuTop (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rdy,
    input  logic [memPkg::waitWidth-1:0] memWait,
    input  logic                         reqValid,
    input  logic [lsuPkg::opWidth-1:0]   reqOp,
    input  logic [lsuPkg::wordWidth-1:0] reqAddr,
    input  logic [lsuPkg::wordWidth-1:0] reqData,
    input  logic [lsuPkg::tagWidth-1:0]  reqTag,
    output logic                         bufFull,
    output logic                         respValid,
    output logic [lsuPkg::wordWidth-1:0] respData,
    output logic [lsuPkg::tagWidth-1:0]  respTag
);

    logic                         issue;
    logic [lsuPkg::opWidth-1:0]   issueOp;
    logic                         issueStore;
    logic [lsuPkg::lenWidth-1:0]  issueLen;
    logic [lsuPkg::wordWidth-1:0] issueAddr;
    logic [lsuPkg::wordWidth-1:0] issueData;
    logic [lsuPkg::tagWidth-1:0]  issueTag;
    logic                         busy;
    logic                         memEn;
    logic                         memStore;
    logic [lsuPkg::lenWidth-1:0]  memLen;
    logic [memPkg::addrWidth-1:0] memAddr;
    memPkg::dataWord              memData;
    logic                         memDone;
    memPkg::dataWord              memRdata;
    logic                         done;
    memPkg::dataWord              doneData;
    logic [lsuPkg::tagWidth-1:0]  doneTag;

    // decode.
    reqBuffer reqBuffer_i (
        .clk, .rst, .rdy,
        .reqValid, .reqOp, .reqAddr, .reqData, .reqTag,
        .busy, .bufFull,
        .issue, .issueOp, .issueStore, .issueLen, .issueAddr, .issueData, .issueTag
    );

    // execute.
    dcache dcache_i (
        .clk, .rst, .rdy,
        .issue, .issueStore, .issueLen, .issueAddr, .issueData, .issueTag,
        .memDone, .memRdata,
        .busy, .memEn, .memStore, .memLen, .memAddr, .memData,
        .done, .doneData, .doneTag
    );

    memCtrl memCtrl_i (
        .clk, .rst, .rdy, .memWait,
        .memEn, .memStore, .memLen, .memAddr, .memData,
        .memDone, .memRdata
    );

    // result.
    loadFormat loadFormat_i (
        .clk, .rst, .rdy,
        .issue, .issueOp,
        .done, .doneData,
        .respValid, .respData
    );

    // tag lines up with respValid, one cycle after done.
    always_ff @(posedge clk) begin
        if (rdy && done) begin
            respTag <= doneTag;
        end
    end

endmodule

//--- rtl/memCtrl.sv
`timescale 1ns/1ps

module memCtrl (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rdy,
    input  logic [memPkg::waitWidth-1:0] memWait,
    input  logic                         memEn,
    input  logic                         memStore,
    input  logic [lsuPkg::lenWidth-1:0]  memLen,
    input  logic [memPkg::addrWidth-1:0] memAddr,
    input  memPkg::dataWord              memData,
    output logic                         memDone,
    output memPkg::dataWord              memRdata
);

    logic [memPkg::byteWidth-1:0]    ram [memPkg::ramDepth];

    logic                            active;
    logic [lsuPkg::lenWidth-1:0]     byteIdx;
    logic [memPkg::waitWidth-1:0]    waitCnt;
    logic [memPkg::waitWidth-1:0]    waitLimit;
    logic [lsuPkg::lenWidth-1:0]     lastIdx;
    logic                            store;
    logic [memPkg::ramAddrWidth-1:0] base;
    memPkg::dataWord                 wrBuf;
    logic [memPkg::ramAddrWidth-1:0] ramIdx;
    logic                            byteStep;

    // wraps at the top of the RAM.
    assign ramIdx   = base + memPkg::ramAddrWidth'(byteIdx);
    assign byteStep = active && (waitCnt == waitLimit);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // byte and wait sequencing.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            active  <= 1'b0;
            memDone <= 1'b0;
            byteIdx <= '0;
            waitCnt <= '0;
        end else if (rdy) begin
            memDone <= 1'b0;
            if (memEn) begin
                active  <= 1'b1;
                byteIdx <= '0;
                waitCnt <= '0;
            end else if (byteStep) begin
                waitCnt <= '0;
                if (byteIdx == lastIdx) begin
                    active  <= 1'b0;
                    memDone <= 1'b1;
                end else begin
                    byteIdx <= byteIdx + 1'b1;
                end
            end else if (active) begin
                waitCnt <= waitCnt + 1'b1;
            end
        end
    end

    // read word starts at zero, so stores and short loads return zeros above.
    always_ff @(posedge clk) begin
        if (rdy) begin
            if (memEn) begin
                waitLimit <= memWait;
                lastIdx   <= memLen;
                store     <= memStore;
                base      <= memAddr[memPkg::ramAddrWidth-1:0];
                wrBuf     <= memData;
                memRdata  <= '0;
            end else if (byteStep) begin
                if (store) begin
                    ram[ramIdx] <= wrBuf.lanes[byteIdx];
                end else begin
                    memRdata.lanes[byteIdx] <= ram[ramIdx];
                end
            end
        end
    end

endmodule

//--- rtl/memPkg.sv
package memPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // memory side sizes.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int addrWidth = lsuPkg::wordWidth;

    // only the low address bits reach the RAM, so accesses wrap.
    localparam int ramAddrWidth = 8;
    localparam int ramDepth     = 1 << ramAddrWidth;

    // extra cycles spent on every byte.
    localparam int waitWidth = 2;

    localparam int byteWidth = 8;
    localparam int halfWidth = 2 * byteWidth;
    localparam int laneCount = lsuPkg::wordWidth / byteWidth;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // memory data word.
    // lane 0 holds the byte at the lowest address.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef union packed {
        logic [lsuPkg::wordWidth-1:0]        word;
        logic [laneCount-1:0][byteWidth-1:0] lanes;
    } dataWord;

endpackage

//--- rtl/reqBuffer.sv
`timescale 1ns/1ps

module reqBuffer (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rdy,
    input  logic                         reqValid,
    input  logic [lsuPkg::opWidth-1:0]   reqOp,
    input  logic [lsuPkg::wordWidth-1:0] reqAddr,
    input  logic [lsuPkg::wordWidth-1:0] reqData,
    input  logic [lsuPkg::tagWidth-1:0]  reqTag,
    input  logic                         busy,
    output logic                         bufFull,
    output logic                         issue,
    output logic [lsuPkg::opWidth-1:0]   issueOp,
    output logic                         issueStore,
    output logic [lsuPkg::lenWidth-1:0]  issueLen,
    output logic [lsuPkg::wordWidth-1:0] issueAddr,
    output logic [lsuPkg::wordWidth-1:0] issueData,
    output logic [lsuPkg::tagWidth-1:0]  issueTag
);

    logic [lsuPkg::opWidth-1:0]    opMem   [lsuPkg::bufDepth];
    logic [lsuPkg::wordWidth-1:0]  addrMem [lsuPkg::bufDepth];
    logic [lsuPkg::wordWidth-1:0]  dataMem [lsuPkg::bufDepth];
    logic [lsuPkg::tagWidth-1:0]   tagMem  [lsuPkg::bufDepth];
    logic [lsuPkg::ptrWidth-1:0]   wrPtr;
    logic [lsuPkg::ptrWidth-1:0]   rdPtr;
    logic [lsuPkg::countWidth-1:0] count;
    logic                          push;

    assign bufFull = (count == lsuPkg::bufDepth);
    assign push    = reqValid && !bufFull;
    assign issue   = (count != '0) && !busy;

    assign issueOp   = opMem[rdPtr];
    assign issueAddr = addrMem[rdPtr];
    assign issueData = dataMem[rdPtr];
    assign issueTag  = tagMem[rdPtr];

    // signedness of the head op is resolved later in loadFormat.
    always_comb begin
        case (issueOp)
            lsuPkg::opSb, lsuPkg::opSh, lsuPkg::opSw: issueStore = 1'b1;
            default:                                  issueStore = 1'b0;
        endcase
        case (issueOp)
            lsuPkg::opLb, lsuPkg::opLbu, lsuPkg::opSb: issueLen = lsuPkg::lenByte;
            lsuPkg::opLh, lsuPkg::opLhu, lsuPkg::opSh: issueLen = lsuPkg::lenHalf;
            default:                                   issueLen = lsuPkg::lenWord;
        endcase
    end

    // pointers wrap on their own since the depth is a power of two.
    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else if (rdy) begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (issue) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({push, issue})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && push) begin
            opMem[wrPtr]   <= reqOp;
            addrMem[wrPtr] <= reqAddr;
            dataMem[wrPtr] <= reqData;
            tagMem[wrPtr]  <= reqTag;
        end
    end

endmodule

//--- testbench/lsuTb.sv
`timescale 1ns/1ps

module lsuTb;

    localparam int initOps       = 64;
    localparam int directedOps   = 21;
    localparam int randOps       = 115;
    localparam int totalOps      = initOps + directedOps + randOps;
    localparam int timeoutCycles = totalOps * 4 * 4 + 200;

    logic                         clk;
    logic                         rst;
    logic                         rdy;
    logic [memPkg::waitWidth-1:0] memWait;
    logic                         reqValid;
    logic [lsuPkg::opWidth-1:0]   reqOp;
    logic [lsuPkg::wordWidth-1:0] reqAddr;
    logic [lsuPkg::wordWidth-1:0] reqData;
    logic [lsuPkg::tagWidth-1:0]  reqTag;
    logic                         bufFull;
    logic                         respValid;
    logic [lsuPkg::wordWidth-1:0] respData;
    logic [lsuPkg::tagWidth-1:0]  respTag;

    // reference memory and expected responses in request order.
    logic [memPkg::byteWidth-1:0] refMem [memPkg::ramDepth];
    logic [lsuPkg::tagWidth-1:0]  expTagQ[$];
    logic [lsuPkg::wordWidth-1:0] expDataQ[$];
    logic [lsuPkg::tagWidth-1:0]  nextTag;
    string                        testName;
    logic                         sawFull;
    int                           cycleCount;
    logic                         heldValid;
    logic [lsuPkg::wordWidth-1:0] heldData;
    logic [lsuPkg::tagWidth-1:0]  heldTag;

    lsuTop lsuTop_i (
        .clk, .rst, .rdy, .memWait,
        .reqValid, .reqOp, .reqAddr, .reqData, .reqTag,
        .bufFull, .respValid, .respData, .respTag
    );

    always #10 clk = ~clk;

    task automatic failRun(input string line);
        $display("%s", line);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    function automatic string mismatchLine(input string field, input logic [31:0] expVal,
                                           input logic [31:0] actVal);
        return $sformatf("FAILED %s: %s expected %08h actual %08h",
                         testName, field, expVal, actVal);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] modelAccess(input logic [2:0] op, input logic [31:0] addr,
                                                input logic [31:0] data);
        int         nBytes;
        int         i;
        logic [7:0] idx;
        logic [31:0] word;
        logic       isStore;
        isStore = (op == lsuPkg::opSb) || (op == lsuPkg::opSh) || (op == lsuPkg::opSw);
        if (op == lsuPkg::opLb || op == lsuPkg::opLbu || op == lsuPkg::opSb) begin
            nBytes = 1;
        end else if (op == lsuPkg::opLh || op == lsuPkg::opLhu || op == lsuPkg::opSh) begin
            nBytes = 2;
        end else begin
            nBytes = 4;
        end
        word = '0;
        // bytes go upward from the address and wrap at the top of the RAM.
        for (i = 0; i < nBytes; i++) begin
            idx = addr[7:0] + 8'(i);
            if (isStore) begin
                refMem[idx] = data[8*i +: 8];
            end else begin
                word[8*i +: 8] = refMem[idx];
            end
        end
        case (op)
            lsuPkg::opLb:  return {{24{word[7]}}, word[7:0]};
            lsuPkg::opLh:  return {{16{word[15]}}, word[15:0]};
            lsuPkg::opLbu: return {24'h0, word[7:0]};
            lsuPkg::opLhu: return {16'h0, word[15:0]};
            lsuPkg::opLw:  return word;
            default:       return 32'h0;
        endcase
    endfunction

    // strobes one request on a falling edge once the buffer has room.
    task automatic sendReq(input logic [2:0] op, input logic [31:0] addr,
                           input logic [31:0] data);
        while (bufFull) begin
            reqValid = 1'b0;
            @(negedge clk);
        end
        reqValid = 1'b1;
        reqOp    = op;
        reqAddr  = addr;
        reqData  = data;
        reqTag   = nextTag;
        expTagQ.push_back(nextTag);
        expDataQ.push_back(modelAccess(op, addr, data));
        nextTag  = nextTag + 1'b1;
        @(negedge clk);
        reqValid = 1'b0;
    endtask

    task automatic drain();
        while (expTagQ.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // response checks and run limit.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= timeoutCycles) begin
            failRun($sformatf("run timed out after %0d cycles", cycleCount));
        end
        // every buffered entry is still waiting for its response.
        if (!rst) begin
            sawFull = sawFull | bufFull;
            assert (!bufFull || expTagQ.size() >= lsuPkg::bufDepth)
                else failRun("bufFull was high with fewer than four requests outstanding");
        end
        // a frozen cycle holds respValid, so only a cycle with rdy high counts.
        if (!rst && rdy && respValid) begin
            if (expTagQ.size() == 0) begin
                failRun($sformatf("response with tag %0h arrived with nothing pending", respTag));
            end else begin
                assert (respTag == expTagQ[0])
                    else failRun(mismatchLine("respTag", 32'(expTagQ[0]), 32'(respTag)));
                assert (respData == expDataQ[0])
                    else failRun(mismatchLine("respData", expDataQ[0], respData));
                void'(expTagQ.pop_front());
                void'(expDataQ.pop_front());
            end
        end
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        rdy        = 1'b1;
        memWait    = '0;
        reqValid   = 1'b0;
        reqOp      = '0;
        reqAddr    = '0;
        reqData    = '0;
        reqTag     = '0;
        nextTag    = '0;
        sawFull    = 1'b0;
        cycleCount = 0;
        testName   = "reset";
        void'($urandom(32'h91105ddc));

        repeat (3) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (!respValid && !bufFull)
            else failRun("respValid or bufFull was high right after reset");

        // fill the whole RAM so later loads read known bytes.
        testName = "ram fill";
        for (int a = 0; a < initOps; a++) begin
            sendReq(lsuPkg::opSw, 32'(a * 4), $urandom);
        end

        testName = "store then load word";
        sendReq(lsuPkg::opSw, 32'h40, 32'hdeadbeef);
        sendReq(lsuPkg::opLw, 32'h40, 32'h0);

        testName = "load extension";
        sendReq(lsuPkg::opSw, 32'h80, 32'h7f80ff81);
        sendReq(lsuPkg::opLb, 32'h80, 32'h0);
        sendReq(lsuPkg::opLbu, 32'h80, 32'h0);
        sendReq(lsuPkg::opLh, 32'h80, 32'h0);
        sendReq(lsuPkg::opLhu, 32'h80, 32'h0);
        sendReq(lsuPkg::opLh, 32'h82, 32'h0);

        testName = "partial stores";
        sendReq(lsuPkg::opSw, 32'h90, 32'h11223344);
        sendReq(lsuPkg::opSb, 32'h91, 32'h000000a5);
        sendReq(lsuPkg::opLw, 32'h90, 32'h0);
        // misaligned half crossing into the next word.
        sendReq(lsuPkg::opSh, 32'h93, 32'h0000beef);
        sendReq(lsuPkg::opLw, 32'h90, 32'h0);
        sendReq(lsuPkg::opLw, 32'h94, 32'h0);
        // upper address bits are ignored, so this wraps to 0x00.
        sendReq(lsuPkg::opSw, 32'h0003_00fe, 32'hcafef00d);
        sendReq(lsuPkg::opLw, 32'hfe, 32'h0);
        sendReq(lsuPkg::opLh, 32'hff, 32'h0);
        drain();

        testName = "back-pressure burst";
        sawFull  = 1'b0;
        for (int n = 0; n < randOps; n++) begin
            memWait = 2'($urandom_range(0, 3));
            sendReq(3'($urandom_range(0, 7)), $urandom, $urandom);
        end
        drain();
        assert (sawFull) else failRun("bufFull never rose during the back-pressure burst");

        testName = "stall";
        memWait = 2'd3;
        for (int n = 0; n < 4; n++) begin
            sendReq(lsuPkg::opLw, $urandom, 32'h0);
        end
        repeat (6) @(negedge clk);
        rdy       = 1'b0;
        heldValid = respValid;
        heldData  = respData;
        heldTag   = respTag;
        repeat (10) begin
            @(negedge clk);
            assert (respValid == heldValid) else failRun("respValid moved while rdy was low");
            assert (respData === heldData && respTag === heldTag)
                else failRun("respData or respTag moved while rdy was low");
        end
        rdy = 1'b1;
        drain();

        $display(">>> PASS");
        $finish;
    end

endmodule
